//--- rtl/iommu_ptw_pkg.sv
`default_nettype none

package iommu_ptw_pkg;

    // Sv39 address widths
    localparam int unsigned VLEN    = 39;
    localparam int unsigned PLEN    = 56;
    localparam int unsigned PPNW    = 44;
    localparam int unsigned VPNW    = 27;

    // Process context tag carried into the IOTLB
    localparam int unsigned PSCID_W = 20;

    // One entry per memory beat
    localparam int unsigned PTE_W   = 64;

    // Entry flag positions
    localparam int unsigned PTE_V     = 0;
    localparam int unsigned PTE_R     = 1;
    localparam int unsigned PTE_W_BIT = 2;
    localparam int unsigned PTE_X     = 3;
    localparam int unsigned PTE_U     = 4;
    localparam int unsigned PTE_G     = 5;
    localparam int unsigned PTE_A     = 6;
    localparam int unsigned PTE_D     = 7;

    // PPN field starts above RSW
    localparam int unsigned PTE_PPN_LSB  = 10;
    // Bits 63:54 belong to Svnapot/Svpbmt, not implemented here
    localparam int unsigned PTE_RSVD_LSB = 54;

    // Fault cause encodings
    localparam int unsigned CAUSE_W = 12;
    localparam logic [CAUSE_W-1:0] CAUSE_LD_PAGE_FAULT = 12'd13;
    localparam logic [CAUSE_W-1:0] CAUSE_ST_PAGE_FAULT = 12'd15;

    // Walk level, LVL1 is the root table
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } ptw_lvl_e;

    // Walker states
    typedef enum logic [1:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        PROPAGATE_ERROR
    } ptw_state_e;

endpackage

`default_nettype wire

//--- rtl/ptw_pte_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ptw_pte_if;

    // Entry under test and its context
    logic [63:0] pte;
    logic [1:0]  lvl;
    logic        is_store;
    logic        check;

    // Verdict valid in the same cycle as check
    logic        is_leaf;
    logic        is_pointer;
    logic        fault;
    logic [11:0] cause;

    modport walker (
        output pte, lvl, is_store, check,
        input  is_leaf, is_pointer, fault, cause
    );

    modport checker_side (
        input  pte, lvl, is_store, check,
        output is_leaf, is_pointer, fault, cause
    );

endinterface

`default_nettype wire

//--- rtl/ptw_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module ptw_mem_port import iommu_ptw_pkg::*; (
    input  wire logic             clk_i,
    input  wire logic             rst_ni,
    input  wire logic             issue_i,
    input  wire logic [PLEN-1:0]  addr_i,
    input  wire logic             mem_gnt_i,
    input  wire logic             mem_rvalid_i,
    input  wire logic [PTE_W-1:0] mem_rdata_i,
    output logic                  mem_req_o,
    output logic [PLEN-1:0]       mem_addr_o,
    output logic                  granted_o,
    output logic [PTE_W-1:0]      rdata_o,
    output logic                  rvalid_o
);

    // Set between a grant and its response
    logic pend_q;
    logic rvalid_q;
    logic [PTE_W-1:0] rdata_q;

    // Request and address follow the walker, which holds both until grant
    assign mem_req_o  = issue_i;
    assign mem_addr_o = addr_i;
    assign granted_o  = issue_i & mem_gnt_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pend_q   <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (granted_o) begin
                pend_q <= 1'b1;
            end else if (mem_rvalid_i) begin
                pend_q <= 1'b0;
            end
            // Ignore responses we did not ask for
            rvalid_q <= mem_rvalid_i & (pend_q | granted_o);
        end
    end

    // Data register, walker sees it one cycle after rvalid
    always_ff @(posedge clk_i) begin
        if (mem_rvalid_i) begin
            rdata_q <= mem_rdata_i;
        end
    end

    assign rdata_o  = rdata_q;
    assign rvalid_o = rvalid_q;

endmodule

`default_nettype wire

//--- rtl/pte_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pte_checker import iommu_ptw_pkg::*; (
    ptw_pte_if.checker_side pte_if
);

    logic invalid;
    logic rsvd_set;
    logic leaf_type;
    logic misaligned;
    logic leaf_bad;
    logic ptr_bad;

    // V clear, or the W-without-R encoding
    assign invalid = !pte_if.pte[PTE_V] || (!pte_if.pte[PTE_R] && pte_if.pte[PTE_W_BIT]);

    assign rsvd_set = |pte_if.pte[PTE_W-1:PTE_RSVD_LSB];

    // R or X marks a leaf
    assign leaf_type = pte_if.pte[PTE_R] || pte_if.pte[PTE_X];

    // Superpage PPN must be aligned to its size
    assign misaligned =
        ((pte_if.lvl == LVL1) && (|pte_if.pte[PTE_PPN_LSB +: 18])) ||
        ((pte_if.lvl == LVL2) && (|pte_if.pte[PTE_PPN_LSB +: 9]));

    // Without hardware A/D update a clear bit faults
    assign leaf_bad = misaligned
                   || !pte_if.pte[PTE_A]
                   || !pte_if.pte[PTE_R]
                   || (pte_if.is_store && !pte_if.pte[PTE_D]);

    // A, D and U are reserved on pointers; LVL3 has nowhere to point
    assign ptr_bad = pte_if.pte[PTE_A]
                  || pte_if.pte[PTE_D]
                  || pte_if.pte[PTE_U]
                  || (pte_if.lvl == LVL3);

    always_comb begin
        pte_if.is_leaf    = 1'b0;
        pte_if.is_pointer = 1'b0;
        pte_if.fault      = 1'b0;
        if (pte_if.check) begin
            // First matching rule wins
            if (invalid || rsvd_set) begin
                pte_if.fault = 1'b1;
            end else if (leaf_type) begin
                pte_if.fault   = leaf_bad;
                pte_if.is_leaf = !leaf_bad;
            end else begin
                pte_if.fault      = ptr_bad;
                pte_if.is_pointer = !ptr_bad;
            end
        end
    end

    // Page fault type follows the original access
    assign pte_if.cause = pte_if.is_store ? CAUSE_ST_PAGE_FAULT : CAUSE_LD_PAGE_FAULT;

endmodule

`default_nettype wire

//--- rtl/ptw_walk_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ptw_walk_ctrl import iommu_ptw_pkg::*; (
    input  wire logic             clk_i,
    input  wire logic             rst_ni,
    input  wire logic             dtf_i,
    input  wire logic             is_store_i,
    input  wire logic             iotlb_access_i,
    input  wire logic             iotlb_hit_i,
    input  wire logic [VLEN-1:0]  req_iova_i,
    input  wire logic [PPNW-1:0]  iosatp_ppn_i,
    input  wire logic             granted_i,
    input  wire logic [PTE_W-1:0] rdata_i,
    input  wire logic             rvalid_i,
    output logic                  issue_o,
    output logic [PLEN-1:0]       addr_o,
    output logic                  ptw_active_o,
    output logic                  ptw_error_o,
    output logic [CAUSE_W-1:0]    cause_code_o,
    output logic                  walk_start_o,
    output logic                  walk_done_o,
    output logic [1:0]            leaf_lvl_o,
    ptw_pte_if.walker             pte_if
);

    ptw_state_e state_q, state_n;
    ptw_lvl_e   lvl_q, lvl_n;

    // Pointer of the entry being fetched
    logic [PLEN-1:0] pptr_q;
    // VPN[1] and VPN[0], needed after the root level
    logic [17:0] vpn_lo_q;
    logic [CAUSE_W-1:0] cause_q;

    logic start_walk;
    logic take_ptr;
    logic take_fault;
    logic [8:0] vpn_next;
    logic [PLEN-1:0] first_ptr;
    logic [PLEN-1:0] next_ptr;

    // Miss while idle starts a walk
    assign start_walk = (state_q == IDLE) && iotlb_access_i && !iotlb_hit_i;

    // Entry goes to the checker as soon as it is registered
    assign pte_if.pte      = rdata_i;
    assign pte_if.lvl      = lvl_q;
    assign pte_if.is_store = is_store_i;
    assign pte_if.check    = (state_q == PTE_LOOKUP) && rvalid_i;

    assign take_ptr   = pte_if.check && pte_if.is_pointer;
    assign take_fault = pte_if.check && pte_if.fault;

    // Root pointer from IOSATP and VPN[2], 8 bytes per entry
    assign first_ptr = {iosatp_ppn_i, req_iova_i[38:30], 3'b000};
    assign vpn_next  = (lvl_q == LVL1) ? vpn_lo_q[17:9] : vpn_lo_q[8:0];
    assign next_ptr  = {rdata_i[PTE_PPN_LSB +: PPNW], vpn_next, 3'b000};

    always_comb begin
        state_n      = state_q;
        lvl_n        = lvl_q;
        issue_o      = 1'b0;
        walk_done_o  = 1'b0;
        ptw_error_o  = 1'b0;
        cause_code_o = '0;
        case (state_q)
            IDLE: begin
                lvl_n = LVL1;
                if (start_walk) begin
                    state_n = WAIT_GRANT;
                end
            end
            WAIT_GRANT: begin
                // Held until the memory accepts it
                issue_o = 1'b1;
                if (granted_i) begin
                    state_n = PTE_LOOKUP;
                end
            end
            PTE_LOOKUP: begin
                if (take_fault) begin
                    // DTF drops the report, walk just ends
                    state_n = dtf_i ? IDLE : PROPAGATE_ERROR;
                end else if (pte_if.check && pte_if.is_leaf) begin
                    walk_done_o = 1'b1;
                    state_n     = IDLE;
                end else if (take_ptr) begin
                    state_n = WAIT_GRANT;
                    lvl_n   = (lvl_q == LVL1) ? LVL2 : LVL3;
                end
            end
            PROPAGATE_ERROR: begin
                ptw_error_o  = 1'b1;
                cause_code_o = cause_q;
                state_n      = IDLE;
            end
            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            lvl_q   <= LVL1;
        end else begin
            state_q <= state_n;
            lvl_q   <= lvl_n;
        end
    end

    // Walk data path
    always_ff @(posedge clk_i) begin
        if (start_walk) begin
            pptr_q   <= first_ptr;
            vpn_lo_q <= req_iova_i[29:12];
        end else if (take_ptr) begin
            pptr_q <= next_ptr;
        end
        if (take_fault) begin
            cause_q <= pte_if.cause;
        end
    end

    assign addr_o       = pptr_q;
    assign ptw_active_o = (state_q != IDLE);
    assign walk_start_o = start_walk;
    assign leaf_lvl_o   = lvl_q;

endmodule

`default_nettype wire

//--- rtl/iotlb_update_gen.sv
`timescale 1ns/1ps
`default_nettype none

module iotlb_update_gen import iommu_ptw_pkg::*; (
    input  wire logic               clk_i,
    input  wire logic               rst_ni,
    input  wire logic               walk_start_i,
    input  wire logic               walk_done_i,
    input  wire logic [1:0]         leaf_lvl_i,
    input  wire logic [VLEN-1:0]    req_iova_i,
    input  wire logic [PSCID_W-1:0] pscid_i,
    input  wire logic [PTE_W-1:0]   entry_i,
    input  wire logic               entry_valid_i,
    output logic                    update_o,
    output logic                    up_is_2m_o,
    output logic                    up_is_1g_o,
    output logic [VPNW-1:0]         up_vpn_o,
    output logic [PSCID_W-1:0]      up_pscid_o,
    output logic [PTE_W-1:0]        up_content_o
);

    logic global_q;
    logic leaf_g;
    logic [PSCID_W-1:0] pscid_q;
    logic [VPNW-1:0] vpn_q;

    // A G bit anywhere on the path makes the mapping global
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            global_q <= 1'b0;
        end else if (walk_start_i) begin
            global_q <= 1'b0;
        end else if (entry_valid_i && entry_i[PTE_G]) begin
            global_q <= 1'b1;
        end
    end

    // IOTLB tags captured at the miss
    always_ff @(posedge clk_i) begin
        if (walk_start_i) begin
            pscid_q <= pscid_i;
            vpn_q   <= req_iova_i[VLEN-1:12];
        end
    end

    // Leaf entry is still on the bus in the done cycle
    assign leaf_g = global_q | (entry_valid_i & entry_i[PTE_G]);

    always_comb begin
        up_content_o        = entry_i;
        up_content_o[PTE_G] = leaf_g;
    end

    assign update_o   = walk_done_i;
    assign up_is_1g_o = (leaf_lvl_i == LVL1);
    assign up_is_2m_o = (leaf_lvl_i == LVL2);
    assign up_vpn_o   = vpn_q;
    assign up_pscid_o = pscid_q;

endmodule

`default_nettype wire

//--- rtl/iommu_ptw_top.sv
`timescale 1ns/1ps
`default_nettype none

module iommu_ptw_top (
    input  wire logic        clk_i,
    input  wire logic        rst_ni,
    input  wire logic        dtf_i,
    input  wire logic        is_store_i,
    input  wire logic        iotlb_access_i,
    input  wire logic        iotlb_hit_i,
    input  wire logic [38:0] req_iova_i,
    input  wire logic [19:0] pscid_i,
    input  wire logic [43:0] iosatp_ppn_i,
    input  wire logic        mem_gnt_i,
    input  wire logic        mem_rvalid_i,
    input  wire logic [63:0] mem_rdata_i,
    output logic             ptw_active_o,
    output logic             ptw_error_o,
    output logic [11:0]      cause_code_o,
    output logic             mem_req_o,
    output logic [55:0]      mem_addr_o,
    output logic             update_o,
    output logic             up_is_2m_o,
    output logic             up_is_1g_o,
    output logic [26:0]      up_vpn_o,
    output logic [19:0]      up_pscid_o,
    output logic [63:0]      up_content_o
);

    logic        issue;
    logic [55:0] addr;
    logic        granted;
    logic [63:0] rdata;
    logic        rvalid;
    logic        walk_start;
    logic        walk_done;
    logic [1:0]  leaf_lvl;

    // Entry and verdict between walker and checker
    ptw_pte_if pte_if ();

    ptw_mem_port mem_port_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .issue_i      (issue),
        .addr_i       (addr),
        .mem_gnt_i    (mem_gnt_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .granted_o    (granted),
        .rdata_o      (rdata),
        .rvalid_o     (rvalid)
    );

    ptw_walk_ctrl walk_ctrl_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .dtf_i          (dtf_i),
        .is_store_i     (is_store_i),
        .iotlb_access_i (iotlb_access_i),
        .iotlb_hit_i    (iotlb_hit_i),
        .req_iova_i     (req_iova_i),
        .iosatp_ppn_i   (iosatp_ppn_i),
        .granted_i      (granted),
        .rdata_i        (rdata),
        .rvalid_i       (rvalid),
        .issue_o        (issue),
        .addr_o         (addr),
        .ptw_active_o   (ptw_active_o),
        .ptw_error_o    (ptw_error_o),
        .cause_code_o   (cause_code_o),
        .walk_start_o   (walk_start),
        .walk_done_o    (walk_done),
        .leaf_lvl_o     (leaf_lvl),
        .pte_if         (pte_if)
    );

    pte_checker pte_checker_inst (
        .pte_if (pte_if)
    );

    iotlb_update_gen update_gen_inst (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .walk_start_i  (walk_start),
        .walk_done_i   (walk_done),
        .leaf_lvl_i    (leaf_lvl),
        .req_iova_i    (req_iova_i),
        .pscid_i       (pscid_i),
        .entry_i       (rdata),
        .entry_valid_i (rvalid),
        .update_o      (update_o),
        .up_is_2m_o    (up_is_2m_o),
        .up_is_1g_o    (up_is_1g_o),
        .up_vpn_o      (up_vpn_o),
        .up_pscid_o    (up_pscid_o),
        .up_content_o  (up_content_o)
    );

endmodule

`default_nettype wire

//--- verification/ptw_props.sv
`timescale 1ns/1ps
`default_nettype none

module ptw_props (
    input wire logic        clk_i,
    input wire logic        rst_ni,
    input wire logic        mem_req_o,
    input wire logic        mem_gnt_i,
    input wire logic [55:0] mem_addr_o,
    input wire logic        update_o,
    input wire logic        ptw_error_o
);

    // Count of failed assertions
    int unsigned fail_count = 0;

    // Request and address held until the grant
    req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o))
        else begin
            $error("memory request changed before its grant");
            fail_count++;
        end

    // Update and error never together
    end_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(update_o && ptw_error_o))
        else begin
            $error("update and error pulses in the same cycle");
            fail_count++;
        end

    update_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        update_o |=> !update_o)
        else begin
            $error("update pulse longer than one cycle");
            fail_count++;
        end

    error_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ptw_error_o |=> !ptw_error_o)
        else begin
            $error("error pulse longer than one cycle");
            fail_count++;
        end

endmodule

`default_nettype wire

//--- verification/ptw_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module ptw_scoreboard (
    input wire logic        clk_i,
    input wire logic        rst_ni,
    input wire logic        access_i,
    input wire logic        hit_i,
    input wire logic        active_i,
    input wire logic        error_i,
    input wire logic [11:0] cause_i,
    input wire logic        update_i,
    input wire logic        is_2m_i,
    input wire logic        is_1g_i,
    input wire logic [26:0] vpn_i,
    input wire logic [19:0] pscid_i,
    input wire logic [63:0] content_i
);

    // Reference copy of the page table keyed by entry address
    logic [63:0] ref_mem [logic [55:0]];

    int n_tests = 0;
    int n_fail = 0;
    int seen_update = 0;
    int seen_error = 0;
    // Expected end as 0 update, 1 reported fault or 2 silent fault
    int exp_kind = 0;
    logic test_bad = 1'b0;
    logic active_q = 1'b0;
    logic hit_q = 1'b0;

    logic [11:0] exp_cause;
    logic [26:0] exp_vpn;
    logic [19:0] exp_pscid;
    logic [63:0] exp_content;
    logic        exp_1g;
    logic        exp_2m;

    task automatic store_entry(input logic [55:0] addr, input logic [63:0] data);
        ref_mem[addr] = data;
    endtask

    task automatic clear_table();
        ref_mem.delete();
    endtask

    // Walk the reference table with the Sv39 rules
    task automatic expect_walk(input logic [38:0] iova, input logic [19:0] pscid,
                               input logic [43:0] satp, input logic is_store,
                               input logic dtf);
        logic [55:0] ptr;
        logic [63:0] pte;
        logic        g;
        logic        done;
        ptr = {satp, iova[38:30], 3'b000};
        g = 1'b0;
        done = 1'b0;
        exp_vpn = iova[38:12];
        exp_pscid = pscid;
        exp_cause = is_store ? 12'h00f : 12'h00d;
        // Assume a fault until a good leaf is found
        exp_kind = dtf ? 2 : 1;
        for (int lvl = 0; lvl < 3 && !done; lvl++) begin
            pte = ref_mem.exists(ptr) ? ref_mem[ptr] : 64'h0;
            done = 1'b1;
            if (!pte[0] || (!pte[1] && pte[2]) || (|pte[63:54])) begin
                // Invalid encoding or reserved bits keep the assumed fault
            end else if (pte[1] || pte[3]) begin
                // Leaf where superpages need an aligned PPN
                if (!(lvl == 0 && (|pte[27:10])) && !(lvl == 1 && (|pte[18:10]))
                    && pte[6] && pte[1] && !(is_store && !pte[7])) begin
                    exp_kind = 0;
                    g = g | pte[5];
                    exp_content = pte;
                    exp_content[5] = g;
                    exp_1g = (lvl == 0);
                    exp_2m = (lvl == 1);
                end
            end else if (!pte[6] && !pte[7] && !pte[4] && lvl != 2) begin
                g = g | pte[5];
                ptr = {pte[53:10], (lvl == 0) ? iova[29:21] : iova[20:12], 3'b000};
                done = 1'b0;
            end
        end
        seen_update = 0;
        seen_error = 0;
        test_bad = 1'b0;
    endtask

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] test %0d %s got 0x%h expected 0x%h", n_tests, name, got, exp);
            test_bad = 1'b1;
        end
    endtask

    task automatic finish_walk();
        compare_field("update_o pulses", 64'(seen_update), 64'((exp_kind == 0) ? 1 : 0));
        compare_field("ptw_error_o pulses", 64'(seen_error), 64'((exp_kind == 1) ? 1 : 0));
        $display("test %0d walk kind %0d %s", n_tests, exp_kind, test_bad ? "failed" : "passed");
        if (test_bad) begin
            n_fail++;
        end
        n_tests++;
    endtask

    task automatic report_counts();
        $display("tests %0d passed %0d failed %0d", n_tests, n_tests - n_fail, n_fail);
    endtask

    // Outputs sampled at the rising edge while inputs change on the falling one
    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (update_i) begin
                seen_update++;
                if (exp_kind == 0) begin
                    compare_field("up_vpn_o", 64'(vpn_i), 64'(exp_vpn));
                    compare_field("up_pscid_o", 64'(pscid_i), 64'(exp_pscid));
                    compare_field("up_content_o", content_i, exp_content);
                    compare_field("up_is_1g_o", 64'(is_1g_i), 64'(exp_1g));
                    compare_field("up_is_2m_o", 64'(is_2m_i), 64'(exp_2m));
                end
            end
            if (error_i) begin
                seen_error++;
                if (exp_kind == 1) begin
                    compare_field("cause_code_o", 64'(cause_i), 64'(exp_cause));
                end
            end
            // Walk ends when the active flag falls
            if (active_q && !active_i) begin
                finish_walk();
            end
            // A hit one cycle earlier must leave the walker idle
            if (hit_q) begin
                if (active_i) begin
                    $display("test %0d an IOTLB hit started a walk", n_tests);
                    n_fail++;
                end else begin
                    $display("test %0d hit passed", n_tests);
                end
                n_tests++;
            end
            hit_q = access_i && hit_i;
            active_q = active_i;
        end
    end

endmodule

`default_nettype wire

//--- verification/iommu_ptw_tb.sv
`timescale 1ns/1ps
`default_nettype none

module iommu_ptw_tb;

    localparam int N_TESTS = 200;

    integer seed;
    logic        clk_i;
    logic        rst_ni;
    logic        dtf_i;
    logic        is_store_i;
    logic        iotlb_access_i;
    logic        iotlb_hit_i;
    logic [38:0] req_iova_i;
    logic [19:0] pscid_i;
    logic [43:0] iosatp_ppn_i;
    logic        mem_gnt_i;
    logic        mem_rvalid_i;
    logic [63:0] mem_rdata_i;
    logic        ptw_active_o;
    logic        ptw_error_o;
    logic [11:0] cause_code_o;
    logic        mem_req_o;
    logic [55:0] mem_addr_o;
    logic        update_o;
    logic        up_is_2m_o;
    logic        up_is_1g_o;
    logic [26:0] up_vpn_o;
    logic [19:0] up_pscid_o;
    logic [63:0] up_content_o;

    // Page table image served by the memory model
    logic [63:0] pt_mem [logic [55:0]];

    // 100 ns period
    always #50 clk_i = ~clk_i;

    iommu_ptw_top iommu_ptw_top_inst (.*);

    ptw_scoreboard sb_inst (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .access_i  (iotlb_access_i),
        .hit_i     (iotlb_hit_i),
        .active_i  (ptw_active_o),
        .error_i   (ptw_error_o),
        .cause_i   (cause_code_o),
        .update_i  (update_o),
        .is_2m_i   (up_is_2m_o),
        .is_1g_i   (up_is_1g_o),
        .vpn_i     (up_vpn_o),
        .pscid_i   (up_pscid_o),
        .content_i (up_content_o)
    );

    bind iommu_ptw_top ptw_props props_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .mem_req_o   (mem_req_o),
        .mem_gnt_i   (mem_gnt_i),
        .mem_addr_o  (mem_addr_o),
        .update_o    (update_o),
        .ptw_error_o (ptw_error_o)
    );

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    task automatic write_entry(input logic [55:0] addr, input logic [63:0] data);
        pt_mem[addr] = data;
        sb_inst.store_entry(addr, data);
    endtask

    // Memory model with grant after 0..3 cycles and data 1..3 cycles after grant
    initial begin : mem_model
        logic [55:0] a;
        logic [31:0] r;
        int lat;
        mem_gnt_i = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i = 64'h0;
        forever begin
            @(negedge clk_i);
            mem_gnt_i = 1'b0;
            mem_rvalid_i = 1'b0;
            if (mem_req_o) begin
                r = rand32();
                repeat (r[1:0]) @(negedge clk_i);
                a = mem_addr_o;
                mem_gnt_i = 1'b1;
                @(negedge clk_i);
                mem_gnt_i = 1'b0;
                lat = 1 + int'(r[7:0] % 8'd3);
                repeat (lat - 1) @(negedge clk_i);
                mem_rvalid_i = 1'b1;
                // Missing entries read as zero and are invalid
                mem_rdata_i = pt_mem.exists(a) ? pt_mem[a] : 64'h0;
            end
        end
    end

    // Random table with the leaf at a random level and maybe one broken entry
    task automatic run_walk_test();
        logic [38:0] iova;
        logic [43:0] satp;
        logic [43:0] ppn;
        logic [55:0] ptr;
        logic [63:0] pte;
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] r3;
        logic        inject;
        int leaf;
        int bad_lvl;
        pt_mem.delete();
        sb_inst.clear_table();
        r = rand32();
        r2 = rand32();
        iova = {r[6:0], r2};
        r = rand32();
        r2 = rand32();
        satp = {r[11:0], r2};
        r = rand32();
        leaf = int'(r[7:0]) % 3;
        bad_lvl = int'(r[15:8]) % (leaf + 1);
        inject = r[16];
        ptr = {satp, iova[38:30], 3'b000};
        for (int l = 0; l <= leaf; l++) begin
            r = rand32();
            r2 = rand32();
            r3 = rand32();
            ppn = {r[11:0], r2};
            if (l == leaf) begin
                if (l == 0) begin
                    ppn[17:0] = '0;
                end else if (l == 1) begin
                    ppn[8:0] = '0;
                end
                // D, A, R and V set with W, X and U random
                pte = {10'h000, ppn, 2'b00, 8'hc3};
                pte[2] = r3[0];
                pte[3] = r3[1];
                pte[4] = r3[2];
            end else begin
                pte = {10'h000, ppn, 2'b00, 8'h01};
            end
            pte[5] = (r3[4:3] == 2'd0);
            if (inject && l == bad_lvl) begin
                case (r3[10:8])
                    3'd0: pte[0] = 1'b0;
                    3'd1: begin
                        pte[1] = 1'b0;
                        pte[2] = 1'b1;
                    end
                    3'd2: pte[60] = 1'b1;
                    3'd3: pte[6] = ~pte[6];
                    3'd4: pte[7] = ~pte[7];
                    3'd5: begin
                        pte[10] = 1'b1;
                        pte[4] = 1'b1;
                    end
                    3'd6: begin
                        pte[2:1] = 2'b00;
                        pte[3] = 1'b1;
                    end
                    default: begin
                        // Leaf turned into a pointer
                        pte[3:1] = 3'b000;
                        pte[7:6] = 2'b00;
                    end
                endcase
            end
            write_entry(ptr, pte);
            if (l < leaf) begin
                ptr = {ppn, (l == 0) ? iova[29:21] : iova[20:12], 3'b000};
            end
        end
        r = rand32();
        is_store_i = r[0];
        dtf_i = (r[3:1] == 3'd0);
        pscid_i = r[31:12];
        req_iova_i = iova;
        iosatp_ppn_i = satp;
        sb_inst.expect_walk(iova, r[31:12], satp, r[0], (r[3:1] == 3'd0));
        iotlb_access_i = 1'b1;
        iotlb_hit_i = 1'b0;
        @(negedge clk_i);
        iotlb_access_i = 1'b0;
        while (ptw_active_o) @(negedge clk_i);
        // Give the scoreboard the falling edge of active
        @(negedge clk_i);
    endtask

    task automatic run_hit_test();
        logic [31:0] r;
        r = rand32();
        req_iova_i = {r[6:0], r};
        iotlb_access_i = 1'b1;
        iotlb_hit_i = 1'b1;
        @(negedge clk_i);
        iotlb_access_i = 1'b0;
        iotlb_hit_i = 1'b0;
        repeat (2) @(negedge clk_i);
    endtask

    // Watchdog sized from the test count
    initial begin : watchdog
        repeat (N_TESTS * 40) @(posedge clk_i);
        $display("Watchdog expired, the walker stopped responding");
        $display("Test FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] r;
        seed = 32'h572d5aa9;
        clk_i = 1'b0;
        rst_ni = 1'b0;
        dtf_i = 1'b0;
        is_store_i = 1'b0;
        iotlb_access_i = 1'b0;
        iotlb_hit_i = 1'b0;
        req_iova_i = '0;
        pscid_i = '0;
        iosatp_ppn_i = '0;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);
        for (int t = 0; t < N_TESTS; t++) begin
            r = rand32();
            if (r[2:0] == 3'd0) begin
                run_hit_test();
            end else begin
                run_walk_test();
            end
        end
        repeat (3) @(negedge clk_i);
        sb_inst.report_counts();
        if (sb_inst.n_fail == 0 && sb_inst.n_tests == N_TESTS
            && iommu_ptw_top_inst.props_inst.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
rtl/iommu_ptw_pkg.sv
rtl/ptw_pte_if.sv
rtl/ptw_mem_port.sv
rtl/pte_checker.sv
rtl/ptw_walk_ctrl.sv
rtl/iotlb_update_gen.sv
rtl/iommu_ptw_top.sv
verification/ptw_props.sv
verification/ptw_scoreboard.sv
verification/iommu_ptw_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= iommu_ptw_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
